// File: source/ws2812_pkg.sv
/*
 * WS2812 strip driver shared definitions
 * Sequencer states, pulse timing at 50 MHz and size limits used by
 * the pixel memory, frame sequencer and bit encoder.
 */

`default_nettype none

package ws2812_pkg;

    // frame sequencer states
    typedef enum logic [1:0] {
        idle     = 2'b00,
        read_ram = 2'b01,
        send_bit = 2'b11,
        send_rst = 2'b10
    } ctl_state_e;

    // pixel memory geometry
    localparam int ADDR_W     = 6;
    localparam int COLOR_W    = 24;
    localparam int MAX_PIXELS = 64;

    // one-wire bit timing in clock cycles, 20 ns each
    localparam int T0H_CYCLES  = 20;
    localparam int T1H_CYCLES  = 40;
    localparam int TBIT_CYCLES = 63;

    // reset gap is programmed in units of this many cycles
    localparam int RST_UNIT_CYCLES = 256;

    // counter widths derived from the values above
    localparam int BIT_CNT_W = $clog2(TBIT_CYCLES);
    localparam int PIX_CNT_W = $clog2(MAX_PIXELS + 1);
    localparam int RST_TMR_W = 16;

endpackage

`default_nettype wire

// File: source/ram64.sv
/*
 * Pixel memory
 * 64 x 32 record store. Write port has per-byte enables; read port
 * is registered and only updates when rd_en is high.
 */

`default_nettype none

module ram64
    import ws2812_pkg::*;
(
    input  logic              clk_in,
    input  logic              rst_n_in,

    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [31:0]       wr_data,
    input  logic [3:0]        byte_en,

    input  logic              rd_en,
    input  logic [ADDR_W-1:0] rd_addr,
    output logic [31:0]       rd_q
);

    logic [31:0] mem [2**ADDR_W];

    // array contents survive reset, only the host writes them
    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    mem[wr_addr][8*i +: 8] <= wr_data[8*i +: 8];
                end
            end
        end
    end

    // output register holds the last read word between reads
    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            rd_q <= '0;
        end else if (rd_en) begin
            rd_q <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: source/ws2812_ctl.sv
/*
 * WS2812 frame sequencer
 * Walks the linked pixel chain from address 0, feeds colour bits MSB
 * first to the encoder one strobe at a time and finishes each frame
 * with a programmable low reset gap. A frame stops at the end flag
 * or after MAX_PIXELS pixels, whichever comes first.
 */

`default_nettype none

module ws2812_ctl
    import ws2812_pkg::*;
(
    input  logic              clk_in,
    input  logic              rst_n_in,

    input  logic              frame_rdy,
    input  logic [7:0]        rst_cnt,

    output logic              rd_en,
    output logic [ADDR_W-1:0] rd_addr,
    input  logic [31:0]       rd_q,

    input  logic              bit_done,
    output logic              bit_rdy,
    output logic              bit_data,

    output logic              busy
);

    ctl_state_e           state;

    logic                 rd_done;
    logic                 capture;
    logic                 bit_first;
    logic [4:0]           bit_sel;
    logic [PIX_CNT_W-1:0] pix_cnt;
    logic [RST_TMR_W-1:0] rst_tmr;
    logic [RST_TMR_W-1:0] rst_last;
    logic                 frame_end;

    logic [COLOR_W-1:0]   color;
    logic                 chain_end;

    // memory word is valid the cycle after rd_en, captured one cycle later
    assign capture = (state == read_ram) && rd_done;

    assign frame_end = chain_end || (pix_cnt == PIX_CNT_W'(MAX_PIXELS));

    // gap lasts (rst_cnt + 1) units
    assign rst_last = RST_TMR_W'((32'(rst_cnt) + 32'd1) * RST_UNIT_CYCLES - 1);

    assign busy = (state != idle);

    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            state     <= idle;
            rd_en     <= 1'b0;
            rd_done   <= 1'b0;
            rd_addr   <= '0;
            bit_first <= 1'b0;
            bit_sel   <= '0;
            pix_cnt   <= '0;
            rst_tmr   <= '0;
            bit_rdy   <= 1'b0;
            bit_data  <= 1'b0;
        end else begin
            rd_en   <= 1'b0;
            bit_rdy <= 1'b0;
            rd_done <= rd_en;

            case (state)
                idle: begin
                    // frame_rdy is ignored anywhere else
                    if (frame_rdy) begin
                        state   <= read_ram;
                        rd_addr <= '0;
                        rd_en   <= 1'b1;
                        pix_cnt <= '0;
                    end
                end

                read_ram: begin
                    if (rd_done) begin
                        state     <= send_bit;
                        rd_addr   <= rd_q[24 +: ADDR_W];
                        bit_sel   <= 5'(COLOR_W - 1);
                        bit_first <= 1'b1;
                        pix_cnt   <= pix_cnt + 1'b1;
                    end
                end

                send_bit: begin
                    if (bit_first) begin
                        // colour register is loaded by now
                        bit_first <= 1'b0;
                        bit_rdy   <= 1'b1;
                        bit_data  <= color[bit_sel];
                    end else if (bit_done) begin
                        if (bit_sel == '0) begin
                            if (frame_end) begin
                                state   <= send_rst;
                                rst_tmr <= '0;
                            end else begin
                                state <= read_ram;
                                rd_en <= 1'b1;
                            end
                        end else begin
                            bit_sel  <= bit_sel - 1'b1;
                            bit_rdy  <= 1'b1;
                            bit_data <= color[bit_sel - 1'b1];
                        end
                    end
                end

                send_rst: begin
                    if (rst_tmr == rst_last) begin
                        state <= idle;
                    end else begin
                        rst_tmr <= rst_tmr + 1'b1;
                    end
                end
            endcase
        end
    end

    // current pixel colour and end-of-chain flag
    always_ff @(posedge clk_in) begin
        if (capture) begin
            color     <= rd_q[COLOR_W-1:0];
            chain_end <= rd_q[31];
        end
    end

    // strobes to the encoder only come out of the bit state
    a_bit_rdy_src: assert property (
        @(posedge clk_in) disable iff (!rst_n_in)
        $rose(bit_rdy) |-> $past(state) == send_bit
    );

    // memory reads are single-cycle pulses
    a_rd_en_pulse: assert property (
        @(posedge clk_in) disable iff (!rst_n_in)
        rd_en |=> !rd_en
    );

endmodule

`default_nettype wire

// File: source/ws2812_enc.sv
/*
 * WS2812 bit encoder
 * Turns each bit strobe into one high/low pulse on the strip line and
 * answers with bit_done on the last cycle of the bit period.
 */

`default_nettype none

module ws2812_enc
    import ws2812_pkg::*;
(
    input  logic clk_in,
    input  logic rst_n_in,

    input  logic bit_rdy,
    input  logic bit_data,
    output logic bit_done,

    output logic led_dout
);

    logic                 active;
    logic                 bit_val;
    logic                 last;
    logic [BIT_CNT_W-1:0] cnt;
    logic [BIT_CNT_W-1:0] cnt_nxt;
    logic [BIT_CNT_W-1:0] hi_len;

    assign cnt_nxt = cnt + 1'b1;
    assign last    = (cnt == BIT_CNT_W'(TBIT_CYCLES - 1));

    // high time depends on the latched bit value
    assign hi_len = bit_val ? BIT_CNT_W'(T1H_CYCLES) : BIT_CNT_W'(T0H_CYCLES);

    assign bit_done = active && last;

    always_ff @(posedge clk_in or negedge rst_n_in) begin
        if (!rst_n_in) begin
            active   <= 1'b0;
            cnt      <= '0;
            led_dout <= 1'b0;
        end else if (bit_rdy) begin
            active   <= 1'b1;
            cnt      <= '0;
            led_dout <= 1'b1;
        end else if (active) begin
            cnt      <= cnt_nxt;
            // line drops once hi_len cycles have gone by
            led_dout <= (cnt_nxt < hi_len);
            if (last) begin
                active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (bit_rdy) begin
            bit_val <= bit_data;
        end
    end

    // the sequencer must wait for bit_done before the next strobe
    a_no_overlap: assert property (
        @(posedge clk_in) disable iff (!rst_n_in)
        bit_rdy |-> !active
    );

endmodule

`default_nettype wire

// File: source/ws2812_top.sv
/*
 * WS2812 strip driver top level
 * Pixel memory, frame sequencer and bit encoder. Host bytes are
 * broadcast to all four lanes and byte_en picks the lanes written.
 */

`default_nettype none

module ws2812_top
    import ws2812_pkg::*;
(
    input  logic              clk_in,
    input  logic              rst_n_in,

    input  logic              wr_en,
    input  logic [ADDR_W-1:0] wr_addr,
    input  logic [7:0]        wr_data,
    input  logic [3:0]        byte_en,

    input  logic              frame_rdy,
    input  logic [7:0]        rst_cnt,

    output logic              led_dout,
    output logic              busy
);

    logic              rd_en;
    logic [ADDR_W-1:0] rd_addr;
    logic [31:0]       rd_q;
    logic              bit_rdy;
    logic              bit_data;
    logic              bit_done;

    ram64 i_ram (
        .clk_in   (clk_in),
        .rst_n_in (rst_n_in),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  ({4{wr_data}}),
        .byte_en  (byte_en),
        .rd_en    (rd_en),
        .rd_addr  (rd_addr),
        .rd_q     (rd_q)
    );

    ws2812_ctl i_ctl (
        .clk_in    (clk_in),
        .rst_n_in  (rst_n_in),
        .frame_rdy (frame_rdy),
        .rst_cnt   (rst_cnt),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_q      (rd_q),
        .bit_done  (bit_done),
        .bit_rdy   (bit_rdy),
        .bit_data  (bit_data),
        .busy      (busy)
    );

    ws2812_enc i_enc (
        .clk_in   (clk_in),
        .rst_n_in (rst_n_in),
        .bit_rdy  (bit_rdy),
        .bit_data (bit_data),
        .bit_done (bit_done),
        .led_dout (led_dout)
    );

endmodule

`default_nettype wire

// File: sim/ws2812_tb.sv
/*
 * WS2812 strip driver testbench
 * Table of frames, each with its record writes and reset gap setting.
 * A shadow copy of the pixel memory gives the expected bit stream, and
 * a pulse-width decoder on led_dout gives the received one.
 */

`default_nettype none

module ws2812_tb
    import ws2812_pkg::*;
;

    localparam int NUM_FRAMES    = 6;
    localparam int START_TIMEOUT = 8;
    localparam int FRAME_TIMEOUT = 200000;
    localparam int QUIET_CYCLES  = 300;
    localparam int RETRIG_DELAY  = 200;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [3:0]        be;
        logic [7:0]        data;
    } wr_entry_t;

    logic              clk_in;
    logic              rst_n_in;
    logic              wr_en;
    logic [ADDR_W-1:0] wr_addr;
    logic [7:0]        wr_data;
    logic [3:0]        byte_en;
    logic              frame_rdy;
    logic [7:0]        rst_cnt;
    logic              led_dout;
    logic              busy;

    // stimulus table
    wr_entry_t wr_table [$];
    string     frame_name     [NUM_FRAMES];
    int        frame_wr_first [NUM_FRAMES];
    int        frame_wr_num   [NUM_FRAMES];
    logic [7:0] frame_rst     [NUM_FRAMES];
    bit        frame_retrig   [NUM_FRAMES];

    logic [31:0] model_mem [2**ADDR_W];
    bit          exp_bits [$];
    bit          got_bits [$];
    int          gap_cnt;

    ws2812_top i_dut (
        .clk_in    (clk_in),
        .rst_n_in  (rst_n_in),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .byte_en   (byte_en),
        .frame_rdy (frame_rdy),
        .rst_cnt   (rst_cnt),
        .led_dout  (led_dout),
        .busy      (busy)
    );

    initial begin
        clk_in = 1'b0;
        forever #5 clk_in = ~clk_in;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Finished with errors");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic report_mismatch(input string test, input int exp, input int act);
        report_failure($sformatf("** Error %s: expected %0d, actual %0d", test, exp, act));
    endtask

    task automatic add_write(input int a, input logic [3:0] be, input logic [7:0] d);
        wr_entry_t w;
        w.addr = ADDR_W'(a);
        w.be   = be;
        w.data = d;
        wr_table.push_back(w);
    endtask

    // random colour in lanes 0..2, link and end flag in lane 3
    task automatic add_record(input int a, input logic [7:0] link);
        logic [31:0] rnd;
        for (int l = 0; l < 3; l++) begin
            rnd = $urandom();
            add_write(a, 4'b0001 << l, rnd[7:0]);
        end
        add_write(a, 4'b1000, link);
    endtask

    task automatic set_frame(input int idx, input string name, input int first,
                             input logic [7:0] rst, input bit retrig);
        frame_name[idx]     = name;
        frame_wr_first[idx] = first;
        frame_wr_num[idx]   = wr_table.size() - first;
        frame_rst[idx]      = rst;
        frame_retrig[idx]   = retrig;
    endtask

    task automatic build_table();
        int first;
        logic [31:0] rnd;
        first = wr_table.size();
        add_record(0, 8'h80);
        set_frame(0, "single_pixel", first, 8'd0, 1'b0);
        // link order 0 -> 37 -> 12, address 1 is never reached
        first = wr_table.size();
        add_record(0, 8'd37);
        add_record(37, 8'd12);
        add_record(12, 8'h80);
        add_record(1, 8'h80);
        set_frame(1, "chain_three", first, 8'd1, 1'b0);
        first = wr_table.size();
        rnd = $urandom();
        add_write(37, 4'b0100, rnd[7:0]);
        set_frame(2, "green_only", first, 8'd0, 1'b0);
        first = wr_table.size();
        set_frame(3, "long_gap", first, 8'd3, 1'b0);
        // record 0 points to itself with no end flag
        first = wr_table.size();
        add_write(0, 4'b1000, 8'h00);
        set_frame(4, "self_link_cap", first, 8'd0, 1'b0);
        first = wr_table.size();
        add_record(0, 8'h80);
        set_frame(5, "busy_retrigger", first, 8'd2, 1'b1);
    endtask

    task automatic apply_writes(input int first, input int num);
        wr_entry_t w;
        for (int i = 0; i < num; i++) begin
            w = wr_table[first + i];
            @(posedge clk_in);
            wr_en   <= 1'b1;
            wr_addr <= w.addr;
            wr_data <= w.data;
            byte_en <= w.be;
            for (int l = 0; l < 4; l++) begin
                if (w.be[l]) begin
                    model_mem[w.addr][8*l +: 8] = w.data;
                end
            end
        end
        @(posedge clk_in);
        wr_en   <= 1'b0;
        byte_en <= '0;
    endtask

    // follow the chain from address 0 through the shadow memory
    task automatic expected_stream();
        logic [ADDR_W-1:0] addr;
        logic [31:0]       rec;
        int                pix;
        bit                stop;
        exp_bits.delete();
        addr = '0;
        pix  = 0;
        stop = 1'b0;
        while (!stop) begin
            rec = model_mem[addr];
            for (int b = COLOR_W - 1; b >= 0; b--) begin
                exp_bits.push_back(rec[b]);
            end
            pix++;
            addr = rec[24 +: ADDR_W];
            stop = (rec[31] == 1'b1) || (pix == MAX_PIXELS);
        end
    endtask

    // decode high pulses on led_dout until busy falls
    task automatic capture_frame(input string test);
        int hi;
        int lo;
        int cycles;
        bit finished;
        bit val;
        got_bits.delete();
        hi       = 0;
        lo       = 0;
        cycles   = 0;
        finished = 1'b0;
        while (!finished) begin
            @(negedge clk_in);
            cycles++;
            if (cycles > FRAME_TIMEOUT) begin
                report_failure({"timeout: busy never fell in test ", test});
            end
            if (!busy) begin
                finished = 1'b1;
            end else if (led_dout) begin
                hi++;
                lo = 0;
            end else begin
                if (hi != 0) begin
                    val = (hi > (T0H_CYCLES + T1H_CYCLES) / 2);
                    assert (hi == (val ? T1H_CYCLES : T0H_CYCLES))
                    else report_mismatch({test, " pulse width"},
                                         val ? T1H_CYCLES : T0H_CYCLES, hi);
                    got_bits.push_back(val);
                    hi = 0;
                end
                lo++;
            end
        end
        gap_cnt = lo;
    endtask

    task automatic retrigger_pulse();
        repeat (RETRIG_DELAY) @(posedge clk_in);
        frame_rdy <= 1'b1;
        @(posedge clk_in);
        frame_rdy <= 1'b0;
    endtask

    task automatic check_quiet(input string test);
        repeat (QUIET_CYCLES) begin
            @(negedge clk_in);
            assert (!led_dout && !busy)
            else report_failure({"strip line or busy active after frame end in test ", test});
        end
    endtask

    task automatic run_frame(input int idx);
        string test;
        int    waited;
        int    exp_gap;
        test = frame_name[idx];
        apply_writes(frame_wr_first[idx], frame_wr_num[idx]);
        expected_stream();
        @(posedge clk_in);
        frame_rdy <= 1'b1;
        rst_cnt   <= frame_rst[idx];
        @(posedge clk_in);
        frame_rdy <= 1'b0;
        waited = 0;
        do begin
            @(negedge clk_in);
            waited++;
            if (waited > START_TIMEOUT) begin
                report_failure({"timeout: busy never rose in test ", test});
            end
        end while (!busy);
        fork
            capture_frame(test);
            if (frame_retrig[idx]) retrigger_pulse();
        join
        assert (got_bits.size() == exp_bits.size())
        else report_mismatch({test, " bit count"}, exp_bits.size(), got_bits.size());
        for (int i = 0; i < exp_bits.size(); i++) begin
            assert (got_bits[i] == exp_bits[i])
            else report_mismatch($sformatf("%s bit %0d", test, i), exp_bits[i], got_bits[i]);
        end
        // low rest of the last bit period, then the reset gap
        exp_gap = (TBIT_CYCLES - (exp_bits[$] ? T1H_CYCLES : T0H_CYCLES))
                  + (int'(frame_rst[idx]) + 1) * RST_UNIT_CYCLES;
        assert (gap_cnt >= exp_gap - 2 && gap_cnt <= exp_gap + 2)
        else report_mismatch({test, " reset gap"}, exp_gap, gap_cnt);
        check_quiet(test);
        $display("%s: %0d bits, gap %0d cycles", test, got_bits.size(), gap_cnt);
    endtask

    initial begin
        rst_n_in  = 1'b0;
        wr_en     = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        byte_en   = '0;
        frame_rdy = 1'b0;
        rst_cnt   = '0;
        void'($urandom(32'hc9878e22));
        build_table();
        repeat (4) @(posedge clk_in);
        rst_n_in <= 1'b1;
        @(negedge clk_in);
        assert (led_dout == 1'b0) else report_mismatch("after_reset led_dout", 0, led_dout);
        assert (busy == 1'b0) else report_mismatch("after_reset busy", 0, busy);
        for (int f = 0; f < NUM_FRAMES; f++) begin
            run_frame(f);
        end
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
source/ws2812_pkg.sv
source/ram64.sv
source/ws2812_ctl.sv
source/ws2812_enc.sv
source/ws2812_top.sv
sim/ws2812_tb.sv
